/* Makefile */
SIM  := obj_dir/Vmem_pipe_tb
SRCS := $(filter-out +%,$(shell cat flist.f)) logic/mem_pipe_config.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q '^Testbench passed$$'

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert -f flist.f --top-module mem_pipe_tb -o Vmem_pipe_tb

clean:
	rm -rf obj_dir

/* flist.f */
+incdir+logic
logic/riscv_insn_pkg.sv
logic/pipe_state_pkg.sv
logic/mem_stage.sv
logic/lsu_wb.sv
logic/wb_stage.sv
logic/trap_regs.sv
logic/mem_pipe_top.sv
tb/mem_pipe_tb.sv

/* logic/lsu_wb.sv */
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module lsu_wb
  import riscv_insn_pkg::*;
  import pipe_state_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Mem stage instruction
  input  insn_t                 insn_i,
  input  logic                  bubble_i,
  input  exc_t                  exc_i,
  input  word_t                 memadr_i,
  input  word_t                 wdata_i,
  // To pipeline
  output logic                  stall_o,
  output exc_t                  exc_o,
  output word_t                 rdata_o,
  // Wishbone classic master
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output word_t                 wb_adr_o,
  output word_t                 wb_dat_o,
  output logic [`MP_XLEN/8-1:0] wb_sel_o,
  input  word_t                 wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  wb_err_i
);

  // Bits only this unit raises
  localparam exc_t LSU_EXC = exc_t'((1 << `MP_EXC_LD_MISALIGN) |
                                    (1 << `MP_EXC_ST_MISALIGN) |
                                    (1 << `MP_EXC_BUS_ERR));

  opcode_t    opcode;
  funct3_t    funct3;
  mem_size_e  size;
  logic       is_load;
  logic       is_store;
  logic       misalign;
  logic       access;
  logic       req;
  logic       done;
  lsu_state_e state_q;
  lsu_state_e state_d;
  word_t      rdata_q;

  ////////////////////////////////////////
  // Decode and alignment
  ////////////////////////////////////////

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];

  // Unknown funct3 is left to the illegal check upstream
  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    if (!bubble_i) begin
      if (opcode == OPC_LOAD) is_load = funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU};
      else if (opcode == OPC_STORE) is_store = funct3 inside {F3_B, F3_H, F3_W};
    end
  end

  always_comb begin
    case (funct3[1:0])
      2'b00:   size = SIZE_BYTE;
      2'b01:   size = SIZE_HALF;
      default: size = SIZE_WORD;
    endcase
  end

  always_comb begin
    case (size)
      SIZE_HALF: misalign = memadr_i[0];
      SIZE_WORD: misalign = |memadr_i[1:0];
      default:   misalign = 1'b0;
    endcase
  end

  assign access = (is_load | is_store) & ~misalign;

  // Independent of exc_i, so no path back through the mem stage
  always_comb begin
    exc_o = '0;
    exc_o[`MP_EXC_LD_MISALIGN] = is_load & misalign;
    exc_o[`MP_EXC_ST_MISALIGN] = is_store & misalign;
    exc_o[`MP_EXC_BUS_ERR]     = access & wb_err_i;
  end

  // Earlier exceptions suppress the bus cycle
  assign req = access & ~|(exc_i & ~LSU_EXC);

  ////////////////////////////////////////
  // Bus FSM
  ////////////////////////////////////////

  assign done = wb_ack_i | wb_err_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req && !done) state_d = ACCESS;
      ACCESS:  if (done) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= IDLE;
    else state_q <= state_d;
  end

  // Cycle opens in the first mem stage cycle, no extra latency
  assign wb_cyc_o = req | (state_q == ACCESS);
  assign wb_stb_o = wb_cyc_o;
  assign wb_we_o  = is_store;
  assign wb_adr_o = {memadr_i[`MP_XLEN-1:2], 2'b00};

  // Freeze the pipe until the slave answers
  assign stall_o = wb_cyc_o & ~done;

  // Store bytes replicated onto every lane, sel picks the live ones
  always_comb begin
    wb_sel_o = '1;
    wb_dat_o = wdata_i;
    case (size)
      SIZE_BYTE: begin
        wb_sel_o = 4'b0001 << memadr_i[1:0];
        wb_dat_o = {4{wdata_i[7:0]}};
      end
      SIZE_HALF: begin
        wb_sel_o = 4'b0011 << memadr_i[1:0];
        wb_dat_o = {2{wdata_i[15:0]}};
      end
      default: ;
    endcase
  end

  // Read data for writeback, used the cycle after the ack edge
  always_ff @(posedge clk_i) begin
    if (wb_cyc_o && wb_ack_i && !wb_we_o) rdata_q <= wb_dat_i;
  end

  assign rdata_o = rdata_q;

  a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o |-> wb_cyc_o);

  // Open cycle keeps its request until ack/err
  a_cyc_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_cyc_o && !done |=> wb_cyc_o && $stable(wb_adr_o) && $stable(wb_we_o));

endmodule

/* logic/mem_pipe_config.svh */
`ifndef MEM_PIPE_CONFIG_SVH
`define MEM_PIPE_CONFIG_SVH

// Data and address width of the back end
`define MP_XLEN 32

// PC held by the mem stage after reset
`define MP_PC_INIT 32'h0000_0200

// Exception vector, one bit per cause
`define MP_EXC_W 4

// Bit positions inside the exception vector
`define MP_EXC_ILLEGAL     0
`define MP_EXC_LD_MISALIGN 1
`define MP_EXC_ST_MISALIGN 2
`define MP_EXC_BUS_ERR     3

`endif

/* logic/mem_pipe_top.sv */
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module mem_pipe_top
  import riscv_insn_pkg::*;
  import pipe_state_pkg::*;
#(
  parameter word_t PC_INIT = `MP_PC_INIT
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Execute side
  input  word_t                 ex_pc_i,
  input  insn_t                 ex_insn_i,
  input  logic                  ex_bubble_i,
  input  word_t                 ex_r_i,
  input  word_t                 ex_memadr_i,
  input  word_t                 ex_wdata_i,
  input  exc_t                  ex_exc_i,
  output logic                  ex_stall_o,
  // Wishbone classic
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output word_t                 wb_adr_o,
  output word_t                 wb_dat_o,
  output logic [`MP_XLEN/8-1:0] wb_sel_o,
  input  word_t                 wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  wb_err_i,
  // Register file write port
  output logic                  rf_we_o,
  output reg_idx_t              rf_waddr_o,
  output word_t                 rf_wdata_o,
  // Trap
  input  logic                  trap_clr_i,
  output logic                  trap_pending_o,
  output cause_t                trap_cause_o,
  output word_t                 trap_pc_o
);

  word_t mem_pc;
  insn_t mem_insn;
  logic  mem_bubble;
  word_t mem_r;
  word_t mem_memadr;
  word_t mem_wdata;
  exc_t  mem_exc_dn;
  logic  lsu_stall;
  exc_t  lsu_exc;
  word_t lsu_rdata;
  logic  wb_bubble;
  exc_t  wb_exc;
  word_t wb_pc;
  exc_t  trap_flush;

  assign ex_stall_o = lsu_stall;

  // Stalled access reaches writeback only on its ack edge
  assign wb_bubble = mem_bubble | lsu_stall;

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  mem_stage #(
    .PC_INIT (PC_INIT)
  ) i_mem_stage (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .stall_i   (lsu_stall),
    .pc_i      (ex_pc_i),
    .insn_i    (ex_insn_i),
    .bubble_i  (ex_bubble_i),
    .r_i       (ex_r_i),
    .memadr_i  (ex_memadr_i),
    .wdata_i   (ex_wdata_i),
    .exc_dn_i  (ex_exc_i),
    .lsu_exc_i (lsu_exc),
    .exc_up_i  (trap_flush),
    .pc_o      (mem_pc),
    .insn_o    (mem_insn),
    .bubble_o  (mem_bubble),
    .r_o       (mem_r),
    .memadr_o  (mem_memadr),
    .wdata_o   (mem_wdata),
    .exc_dn_o  (mem_exc_dn),
    // No older stage in this design
    .exc_up_o  ()
  );

  lsu_wb i_lsu_wb (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .insn_i   (mem_insn),
    .bubble_i (mem_bubble),
    .exc_i    (mem_exc_dn),
    .memadr_i (mem_memadr),
    .wdata_i  (mem_wdata),
    .stall_o  (lsu_stall),
    .exc_o    (lsu_exc),
    .rdata_o  (lsu_rdata),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_sel_o (wb_sel_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .wb_err_i (wb_err_i)
  );

  wb_stage i_wb_stage (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .pc_i       (mem_pc),
    .insn_i     (mem_insn),
    .bubble_i   (wb_bubble),
    .r_i        (mem_r),
    .memadr_i   (mem_memadr),
    .exc_i      (mem_exc_dn),
    .rdata_i    (lsu_rdata),
    .rf_we_o    (rf_we_o),
    .rf_waddr_o (rf_waddr_o),
    .rf_wdata_o (rf_wdata_o),
    .exc_o      (wb_exc),
    .pc_o       (wb_pc)
  );

  trap_regs i_trap_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .exc_i     (wb_exc),
    .pc_i      (wb_pc),
    .clr_i     (trap_clr_i),
    .pending_o (trap_pending_o),
    .cause_o   (trap_cause_o),
    .tpc_o     (trap_pc_o),
    .flush_o   (trap_flush)
  );

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module mem_stage
  import riscv_insn_pkg::*;
  import pipe_state_pkg::*;
#(
  parameter word_t PC_INIT = `MP_PC_INIT
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Freeze from the load/store unit
  input  logic  stall_i,
  // From execute
  input  word_t pc_i,
  input  insn_t insn_i,
  input  logic  bubble_i,
  input  word_t r_i,
  input  word_t memadr_i,
  input  word_t wdata_i,
  input  exc_t  exc_dn_i,
  // New bits raised by the load/store unit
  input  exc_t  lsu_exc_i,
  // Exceptions from younger stages
  input  exc_t  exc_up_i,
  // To load/store unit and writeback
  output word_t pc_o,
  output insn_t insn_o,
  output logic  bubble_o,
  output word_t r_o,
  output word_t memadr_o,
  output word_t wdata_o,
  output exc_t  exc_dn_o,
  output exc_t  exc_up_o
);

  logic bubble_q;
  exc_t exc_q;

  ////////////////////////////////////////
  // Exception tracking
  ////////////////////////////////////////

  // Down vector carries the lsu bits to writeback
  assign exc_dn_o = exc_q | lsu_exc_i;
  // Up vector flushes everything older than the trapping instruction
  assign exc_up_o = exc_dn_o | exc_up_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) exc_q <= '0;
    else if (|exc_up_o) exc_q <= '0;
    // Bubbles never carry an exception
    else if (!stall_i) exc_q <= bubble_i ? '0 : exc_dn_i;
  end

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) pc_o <= PC_INIT;
    else if (!stall_i) pc_o <= pc_i;
  end

  // Any exception on its way up kills the instruction entering here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) bubble_q <= 1'b1;
    else if (|exc_up_o) bubble_q <= 1'b1;
    else if (!stall_i) bubble_q <= bubble_i;
  end

  assign bubble_o = bubble_q;

  // Payload
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      insn_o   <= insn_i;
      r_o      <= r_i;
      memadr_o <= memadr_i;
      wdata_o  <= wdata_i;
    end
  end

  // Instruction held in place for the whole bus access
  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i |=> $stable(pc_o) && $stable(insn_o) && $stable(memadr_o));

endmodule

/* logic/pipe_state_pkg.sv */
`include "mem_pipe_config.svh"

package pipe_state_pkg;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Data and address word
  typedef logic [`MP_XLEN-1:0] word_t;

  ////////////////////////////////////////
  // Exceptions and traps
  ////////////////////////////////////////

  // One bit per cause, see MP_EXC_* positions
  typedef logic [`MP_EXC_W-1:0] exc_t;

  // Trap cause is the vector of the trapping instruction
  typedef logic [`MP_EXC_W-1:0] cause_t;

  ////////////////////////////////////////
  // Load/store unit
  ////////////////////////////////////////

  // Bus idle, or a classic cycle waiting for ack/err
  typedef enum logic {
    IDLE,
    ACCESS
  } lsu_state_e;

endpackage

/* logic/riscv_insn_pkg.sv */
package riscv_insn_pkg;

  ////////////////////////////////////////
  // Instruction word and fields
  ////////////////////////////////////////

  typedef logic [31:0] insn_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [4:0]  reg_idx_t;

  // Major opcodes of loads and stores
  localparam opcode_t OPC_LOAD  = 7'b0000011;
  localparam opcode_t OPC_STORE = 7'b0100011;

  // funct3 encodings, shared by loads and stores
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  // Unsigned loads only
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  ////////////////////////////////////////
  // Memory access size
  ////////////////////////////////////////

  // Same encoding as funct3[1:0]
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

endpackage

/* logic/trap_regs.sv */
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module trap_regs
  import pipe_state_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  // Exception and PC leaving writeback
  input  exc_t   exc_i,
  input  word_t  pc_i,
  // Software side acknowledge
  input  logic   clr_i,
  output logic   pending_o,
  output cause_t cause_o,
  output word_t  tpc_o,
  // Up exception into the mem stage
  output exc_t   flush_o
);

  logic   pending_q;
  cause_t cause_q;
  word_t  tpc_q;
  logic   take;

  ////////////////////////////////////////
  // Capture
  ////////////////////////////////////////

  // Only the first trap counts, later ones wait for the clear
  assign take = ~pending_q & |exc_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) pending_q <= 1'b0;
    else if (pending_q) begin
      if (clr_i) pending_q <= 1'b0;
    end
    else if (take) pending_q <= 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cause_q <= '0;
      tpc_q   <= '0;
    end else if (take) begin
      cause_q <= cause_t'(exc_i);
      tpc_q   <= pc_i;
    end
  end

  assign pending_o = pending_q;
  assign cause_o   = cause_q;
  assign tpc_o     = tpc_q;

  ////////////////////////////////////////
  // Flush
  ////////////////////////////////////////

  // Writeback's own exception flushes too, covering the cycle
  // before pending rises
  assign flush_o = exc_i | (pending_q ? exc_t'(cause_q) : '0);

  a_cause_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_o |-> cause_o != '0);

endmodule

/* logic/wb_stage.sv */
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module wb_stage
  import riscv_insn_pkg::*;
  import pipe_state_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // From mem stage
  input  word_t    pc_i,
  input  insn_t    insn_i,
  input  logic     bubble_i,
  input  word_t    r_i,
  input  word_t    memadr_i,
  input  exc_t     exc_i,
  // Latched load data from the load/store unit
  input  word_t    rdata_i,
  // Register file write port
  output logic     rf_we_o,
  output reg_idx_t rf_waddr_o,
  output word_t    rf_wdata_o,
  // To trap registers
  output exc_t     exc_o,
  output word_t    pc_o
);

  word_t   pc_q;
  insn_t   insn_q;
  logic    bubble_q;
  word_t   r_q;
  word_t   memadr_q;
  exc_t    exc_q;
  opcode_t opcode;
  funct3_t funct3;
  word_t   ld_shift;
  word_t   ld_data;

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bubble_q <= 1'b1;
      exc_q    <= '0;
    end else begin
      bubble_q <= bubble_i;
      exc_q    <= exc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_q     <= pc_i;
    insn_q   <= insn_i;
    r_q      <= r_i;
    memadr_q <= memadr_i;
  end

  ////////////////////////////////////////
  // Load alignment
  ////////////////////////////////////////

  assign opcode = insn_q[6:0];
  assign funct3 = insn_q[14:12];

  // Addressed byte or half moved down to bit 0
  assign ld_shift = rdata_i >> {memadr_q[1:0], 3'b000};

  always_comb begin
    case (funct3)
      F3_B:    ld_data = {{(`MP_XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
      F3_H:    ld_data = {{(`MP_XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
      F3_BU:   ld_data = {{(`MP_XLEN-8){1'b0}}, ld_shift[7:0]};
      F3_HU:   ld_data = {{(`MP_XLEN-16){1'b0}}, ld_shift[15:0]};
      default: ld_data = rdata_i;
    endcase
  end

  ////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////

  assign rf_waddr_o = insn_q[11:7];
  assign rf_wdata_o = (opcode == OPC_LOAD) ? ld_data : r_q;

  // No write for bubbles, traps, stores or x0
  assign rf_we_o = ~bubble_q & ~|exc_q & (opcode != OPC_STORE) & (rf_waddr_o != '0);

  assign exc_o = bubble_q ? '0 : exc_q;
  assign pc_o  = pc_q;

endmodule

/* tb/mem_pipe_tb.sv */
`timescale 1ns/100ps
`include "mem_pipe_config.svh"

module mem_pipe_tb
  import riscv_insn_pkg::*;
  import pipe_state_pkg::*;
;

  localparam int K_ALU = 0;
  localparam int K_BUB = 1;
  localparam int K_LD  = 2;
  localparam int K_ST  = 3;
  localparam int K_CLR = 4;
  localparam int NUM   = 26;
  localparam int LIMIT = NUM * 10 + 8;

  logic clk_i = 1'b0;
  logic rst_ni;
  word_t ex_pc_i, ex_r_i, ex_memadr_i, ex_wdata_i;
  insn_t ex_insn_i;
  logic ex_bubble_i, ex_stall_o;
  exc_t ex_exc_i;
  logic wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i, wb_err_i;
  word_t wb_adr_o, wb_dat_o, wb_dat_i;
  logic [3:0] wb_sel_o;
  logic rf_we_o, trap_clr_i, trap_pending_o;
  reg_idx_t rf_waddr_o;
  word_t rf_wdata_o, trap_pc_o;
  cause_t trap_cause_o;

  // Stimulus table with one row per instruction
  int kind [NUM];
  funct3_t f3 [NUM];
  reg_idx_t rd [NUM];
  word_t val [NUM];
  word_t adr [NUM];
  cause_t cause [NUM];
  int n_rows;

  word_t mem [64];
  word_t ref_mem [64];
  // Wait-state count for each access in turn
  int wait_tab [64];
  logic [36:0] exp_q [$];
  int err_cnt, chk_cnt, cycles, accesses, exp_accesses, wait_cnt, seed;
  logic squash;
  word_t trap_pc_exp;
  cause_t trap_cause_exp;
  // Row on the execute inputs needs a bus cycle
  logic ex_access;
  // Row in the mem stage needs a bus cycle
  logic mem_access;

  mem_pipe_top i_mem_pipe_top (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .ex_pc_i (ex_pc_i), .ex_insn_i (ex_insn_i), .ex_bubble_i (ex_bubble_i),
    .ex_r_i (ex_r_i), .ex_memadr_i (ex_memadr_i), .ex_wdata_i (ex_wdata_i),
    .ex_exc_i (ex_exc_i), .ex_stall_o (ex_stall_o),
    .wb_cyc_o (wb_cyc_o), .wb_stb_o (wb_stb_o), .wb_we_o (wb_we_o),
    .wb_adr_o (wb_adr_o), .wb_dat_o (wb_dat_o), .wb_sel_o (wb_sel_o),
    .wb_dat_i (wb_dat_i), .wb_ack_i (wb_ack_i), .wb_err_i (wb_err_i),
    .rf_we_o (rf_we_o), .rf_waddr_o (rf_waddr_o), .rf_wdata_o (rf_wdata_o),
    .trap_clr_i (trap_clr_i), .trap_pending_o (trap_pending_o),
    .trap_cause_o (trap_cause_o), .trap_pc_o (trap_pc_o)
  );

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic word_t fill_word(int idx);
    return 32'h3C5A_96E1 ^ (idx * 32'h0104_1041);
  endfunction

  function automatic insn_t make_insn(int k, funct3_t f, reg_idx_t r);
    if (k == K_LD) return {12'h000, 5'd1, f, r, 7'b0000011};
    if (k == K_ST) return {7'h00, 5'd2, 5'd1, f, 5'd0, 7'b0100011};
    return {7'h00, 5'd3, 5'd4, 3'b000, r, 7'b0110011};
  endfunction

  // Load result by RV32I rules from the reference memory
  function automatic word_t expect_load(funct3_t f, word_t a);
    word_t w;
    w = ref_mem[a[7:2]] >> (8 * a[1:0]);
    case (f)
      3'b000:  return {{24{w[7]}}, w[7:0]};
      3'b001:  return {{16{w[15]}}, w[15:0]};
      3'b100:  return {24'h0, w[7:0]};
      3'b101:  return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic store_ref(funct3_t f, word_t a, word_t d);
    int nb;
    nb = (f == 3'b000) ? 1 : (f == 3'b001) ? 2 : 4;
    for (int b = 0; b < nb; b++)
      ref_mem[a[7:2]][8*(a[1:0]+b) +: 8] = d[8*b +: 8];
  endtask

  task automatic add_row(int k, funct3_t f, reg_idx_t r, word_t v, word_t a, cause_t c);
    kind[n_rows] = k;
    f3[n_rows] = f;
    rd[n_rows] = r;
    val[n_rows] = v;
    adr[n_rows] = a;
    cause[n_rows] = c;
    n_rows++;
  endtask

  task automatic check_value(string what, word_t got, word_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_bubble();
    ex_bubble_i = 1'b1;
    ex_insn_i = '0;
    ex_access = 1'b0;
  endtask

  // Present one row and record what it should do
  task automatic issue_row(int i);
    ex_pc_i = 32'h1000 + 4 * i;
    ex_insn_i = make_insn(kind[i], f3[i], rd[i]);
    ex_bubble_i = (kind[i] == K_BUB);
    ex_r_i = val[i];
    ex_wdata_i = val[i];
    ex_memadr_i = adr[i];
    ex_access = 1'b0;
    if (squash || kind[i] == K_BUB) return;
    if (cause[i] != '0) begin
      squash = 1'b1;
      trap_pc_exp = ex_pc_i;
      trap_cause_exp = cause[i];
      if (cause[i][`MP_EXC_BUS_ERR]) begin
        exp_accesses++;
        ex_access = 1'b1;
      end
      return;
    end
    if (kind[i] == K_ST) begin
      store_ref(f3[i], adr[i], val[i]);
      exp_accesses++;
      ex_access = 1'b1;
    end else if (kind[i] == K_LD) begin
      exp_accesses++;
      ex_access = 1'b1;
      if (rd[i] != 0) exp_q.push_back({rd[i], expect_load(f3[i], adr[i])});
    end else if (rd[i] != 0) begin
      exp_q.push_back({rd[i], val[i]});
    end
  endtask

  task automatic clear_trap();
    while (!trap_pending_o) @(negedge clk_i);
    check_value("trap cause", word_t'(trap_cause_o), word_t'(trap_cause_exp));
    check_value("trap pc", trap_pc_o, trap_pc_exp);
    trap_clr_i = 1'b1;
    @(negedge clk_i);
    trap_clr_i = 1'b0;
    while (trap_pending_o) @(negedge clk_i);
    squash = 1'b0;
  endtask

  ////////////////////////////////////////
  // Wishbone memory model
  ////////////////////////////////////////

  // Replies on the falling edge after 0..3 wait states
  // Word 63 answers with err
  always @(negedge clk_i) begin
    if (wb_ack_i || wb_err_i) begin
      wb_ack_i <= 1'b0;
      wb_err_i <= 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (wait_cnt != 0) wait_cnt <= wait_cnt - 1;
      else begin
        accesses <= accesses + 1;
        wait_cnt <= wait_tab[(accesses + 1) % 64];
        if (wb_adr_o[7:2] == 6'd63) wb_err_i <= 1'b1;
        else begin
          wb_ack_i <= 1'b1;
          wb_dat_i <= mem[wb_adr_o[7:2]];
          for (int b = 0; b < 4; b++)
            if (wb_we_o && wb_sel_o[b]) mem[wb_adr_o[7:2]][8*b +: 8] <= wb_dat_o[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  // Register file writes in program order
  always @(negedge clk_i) begin
    logic [36:0] e;
    if (rst_ni && rf_we_o) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Unexpected register file write to x%0d at %0t ns", rf_waddr_o, $time);
      end else begin
        e = exp_q.pop_front();
        check_value("rf_waddr", word_t'(rf_waddr_o), word_t'(e[36:32]));
        check_value("rf_wdata", rf_wdata_o, e[31:0]);
      end
    end
  end

  // A row moves into the mem stage unless an access there still waits for its answer
  always @(posedge clk_i) begin
    if (!rst_ni) mem_access <= 1'b0;
    else if (!mem_access || wb_ack_i || wb_err_i) mem_access <= ex_access;
  end

  // Stall holds while an expected access waits for the model's answer
  always begin
    @(negedge clk_i);
    #1;
    if (rst_ni) check_value("ex_stall_o", word_t'(ex_stall_o),
                            word_t'(mem_access && !wb_ack_i && !wb_err_i));
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, the pipeline stopped making progress", LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    seed = $urandom(84011);
    rst_ni = 1'b0;
    ex_pc_i = '0;
    ex_r_i = '0;
    ex_memadr_i = '0;
    ex_wdata_i = '0;
    ex_exc_i = '0;
    trap_clr_i = 1'b0;
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    wb_dat_i = '0;
    drive_bubble();
    squash = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
      ref_mem[i] = fill_word(i);
      wait_tab[i] = $urandom % 4;
    end
    wait_cnt = wait_tab[0];
    // ALU results, rd 0 and bubbles
    add_row(K_ALU, 3'b000, 5'd5, 32'h1234_5678, '0, '0);
    add_row(K_ALU, 3'b000, 5'd0, 32'h0000_DEAD, '0, '0);
    add_row(K_BUB, 3'b000, 5'd6, 32'h0BAD_0BAD, '0, '0);
    add_row(K_ALU, 3'b000, 5'd31, 32'hFFFF_0001, '0, '0);
    // Stores of each size
    add_row(K_ST, 3'b010, 5'd0, 32'h1122_3344, 32'h10, '0);
    add_row(K_ST, 3'b001, 5'd0, 32'hAABB_C0DE, 32'h22, '0);
    add_row(K_ST, 3'b000, 5'd0, 32'h0000_00F5, 32'h33, '0);
    add_row(K_ST, 3'b000, 5'd0, 32'h0000_007E, 32'h30, '0);
    // Loads with sign and zero extension
    add_row(K_LD, 3'b010, 5'd1, '0, 32'h10, '0);
    add_row(K_LD, 3'b001, 5'd2, '0, 32'h22, '0);
    add_row(K_LD, 3'b101, 5'd3, '0, 32'h22, '0);
    add_row(K_LD, 3'b000, 5'd4, '0, 32'h33, '0);
    add_row(K_LD, 3'b100, 5'd6, '0, 32'h33, '0);
    add_row(K_LD, 3'b000, 5'd7, '0, 32'h30, '0);
    add_row(K_LD, 3'b010, 5'd8, '0, 32'h44, '0);
    add_row(K_ALU, 3'b000, 5'd9, 32'h0000_0099, '0, '0);
    // Misaligned load squashes the younger ones
    add_row(K_LD, 3'b010, 5'd10, '0, 32'h12, 4'b0010);
    add_row(K_ALU, 3'b000, 5'd11, 32'h0000_0011, '0, '0);
    add_row(K_ST, 3'b000, 5'd0, 32'h0000_00EE, 32'h40, '0);
    add_row(K_CLR, 3'b000, 5'd0, '0, '0, '0);
    // Misaligned store
    add_row(K_ST, 3'b001, 5'd0, 32'h0000_BEEF, 32'h41, 4'b0100);
    add_row(K_ALU, 3'b000, 5'd12, 32'h0000_0012, '0, '0);
    add_row(K_CLR, 3'b000, 5'd0, '0, '0, '0);
    // Bus error on the last word
    add_row(K_LD, 3'b010, 5'd13, '0, 32'hFC, 4'b1000);
    add_row(K_CLR, 3'b000, 5'd0, '0, '0, '0);
    add_row(K_LD, 3'b101, 5'd15, '0, 32'h46, '0);

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    check_value("reset cyc", word_t'(wb_cyc_o), '0);
    check_value("reset stb", word_t'(wb_stb_o), '0);
    check_value("reset rf_we", word_t'(rf_we_o), '0);
    check_value("reset stall", word_t'(ex_stall_o), '0);
    check_value("reset trap_pending", word_t'(trap_pending_o), '0);
    rst_ni = 1'b1;

    for (int i = 0; i < n_rows; i++) begin
      @(negedge clk_i);
      if (kind[i] == K_CLR) begin
        drive_bubble();
        clear_trap();
      end else begin
        issue_row(i);
        #1;
        while (ex_stall_o) begin
          @(negedge clk_i);
          #1;
        end
      end
    end
    @(negedge clk_i);
    drive_bubble();
    while (exp_q.size() != 0 || wb_cyc_o) @(negedge clk_i);
    repeat (4) @(negedge clk_i);

    // Store bytes and lanes end up in the model memory
    for (int i = 0; i < 64; i++) check_value($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    check_value("bus accesses", word_t'(accesses), word_t'(exp_accesses));

    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
